/* src/cpu_pkg.sv */
//------------------------------
// Shared types for the instruction front end. Holds the widths, the
// operation codes, the control-bit layout and the Wishbone and
// pipeline structs. Modules import it inside their bodies.
//------------------------------
`default_nettype none

package cpu_pkg;

   localparam int addr_w    = 12;
   localparam int mem_depth = 4096;
   localparam int pcb_w     = 6;

   // Form-1 operations sit at their opcode high byte, the rest fill the gaps
   typedef enum logic [5:0] {
      op_nop = 6'h00, op_ldi_l, op_mov, op_jsra, op_ret, op_add_l, op_push, op_pop,
      op_lda_l, op_sta_l, op_ld_l, op_st_l, op_ldo_l, op_sto_l, op_cmp,
      op_inc = 6'h0f, op_dec, op_gsr, op_ssr,
      op_beq, op_bne, op_blt, op_bgt, op_bltu, op_bgtu,
      op_jsr = 6'h19, op_jmpa, op_ldi_b, op_ld_b, op_lda_b, op_st_b, op_sta_b,
      op_ldi_s, op_ld_s, op_lda_s, op_st_s, op_sta_s, op_jmp,
      op_and, op_lshr, op_ashl, op_sub_l, op_neg, op_or, op_not, op_ashr, op_xor,
      op_mul_l, op_swi, op_div_l, op_udiv_l, op_mod_l, op_umod_l, op_brk,
      op_ldo_b, op_sto_b, op_ldo_s, op_sto_s,
      op_bge = 6'h3a, op_ble, op_bgeu, op_bleu,
      op_bad = 6'h3f
   } op_e;

   typedef struct packed {
      logic reg0_we;
      logic mem_rd;
      logic reg1_we;
      logic mem_wr;
      logic uses_operand;
      logic branch;
   } pcb_t;

   // Control patterns, bit order as in pcb_t
   localparam logic [pcb_w-1:0] pcb_alu     = 6'b100000;
   localparam logic [pcb_w-1:0] pcb_reg_imm = 6'b100010;
   localparam logic [pcb_w-1:0] pcb_load    = 6'b110000;
   localparam logic [pcb_w-1:0] pcb_lda     = 6'b110010;
   localparam logic [pcb_w-1:0] pcb_store   = 6'b000100;
   localparam logic [pcb_w-1:0] pcb_sta     = 6'b000110;
   localparam logic [pcb_w-1:0] pcb_push    = 6'b100100;
   localparam logic [pcb_w-1:0] pcb_pop     = 6'b111000;
   localparam logic [pcb_w-1:0] pcb_jump    = 6'b000001;
   localparam logic [pcb_w-1:0] pcb_jmpa    = 6'b000011;
   localparam logic [pcb_w-1:0] pcb_call    = 6'b000101;
   localparam logic [pcb_w-1:0] pcb_jsra    = 6'b000111;
   localparam logic [pcb_w-1:0] pcb_ret     = 6'b010001;

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [addr_w-1:0] adr;
      logic [15:0]       dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [15:0] dat;
   } wb_rsp_t;

   // pc is a byte address
   typedef struct packed {
      logic        valid;
      logic [15:0] opcode;
      logic [31:0] operand;
      logic [31:0] pc;
   } fetch_t;

   typedef struct packed {
      logic        valid;
      op_e         op;
      pcb_t        pcb;
      logic [3:0]  reg0_idx;
      logic [3:0]  reg1_idx;
      logic [3:0]  ri_a;
      logic [3:0]  ri_b;
      logic [31:0] operand;
      logic [9:0]  pcrel;
      logic [31:0] pc;
   } dec_t;

   // Opcodes followed by a 32-bit immediate: ldi.l, lda.l, sta.l, jmpa
   function automatic logic is_long_form(input logic [15:0] opcode);
      logic [7:0] hi;
      hi = opcode[15:8];
      return (hi == 8'h01) || (hi == 8'h08) || (hi == 8'h09) || (hi == 8'h1a);
   endfunction

endpackage

`default_nettype wire

/* src/control_rom.sv */
//------------------------------
// Control ROM for form-1 opcodes. Maps the opcode high byte to the
// pipeline control bits; undefined bytes give all zeros.
//------------------------------
`default_nettype none

module control_rom (
   input  wire [7:0]      opcode_i,
   output cpu_pkg::pcb_t  pcb_o
);
   import cpu_pkg::*;

   always_comb
   begin
      case (opcode_i)
         8'h01:                      pcb_o = pcb_reg_imm;
         // mov, add.l, ldi.b, ldi.s
         8'h02, 8'h05, 8'h1b, 8'h20: pcb_o = pcb_alu;
         8'h26, 8'h27, 8'h28, 8'h29: pcb_o = pcb_alu;
         8'h2a, 8'h2b, 8'h2c, 8'h2d: pcb_o = pcb_alu;
         8'h2e, 8'h2f:               pcb_o = pcb_alu;
         8'h31, 8'h32, 8'h33, 8'h34: pcb_o = pcb_alu;
         8'h03:                      pcb_o = pcb_jsra;
         8'h04:                      pcb_o = pcb_ret;
         8'h06:                      pcb_o = pcb_push;
         8'h07:                      pcb_o = pcb_pop;
         8'h08:                      pcb_o = pcb_lda;
         8'h09:                      pcb_o = pcb_sta;
         // Register-indirect and offset loads
         8'h0a, 8'h0c, 8'h1c, 8'h1d: pcb_o = pcb_load;
         8'h21, 8'h22, 8'h36, 8'h38: pcb_o = pcb_load;
         8'h0b, 8'h0d, 8'h1e, 8'h1f: pcb_o = pcb_store;
         8'h23, 8'h24, 8'h37, 8'h39: pcb_o = pcb_store;
         8'h19:                      pcb_o = pcb_call;
         8'h1a:                      pcb_o = pcb_jmpa;
         8'h25, 8'h30:               pcb_o = pcb_jump;
         // nop, cmp, brk and the holes in the map
         default:                    pcb_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
//------------------------------
// Instruction fetch. Walks the program through its own Wishbone
// master, reading the opcode and, for long-form opcodes, the two
// immediate halfwords (high half first). The finished instruction
// stays on fetch_o until decode takes it.
//------------------------------
`default_nettype none

module fetch_unit (
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire                    run_i,
   input  wire                    stall_i,
   input  wire                    flush_i,
   input  wire [31:0]             flush_pc_i,
   output cpu_pkg::wb_req_t       wb_req_o,
   input  wire cpu_pkg::wb_rsp_t  wb_rsp_i,
   output cpu_pkg::fetch_t        fetch_o
);
   import cpu_pkg::*;

   typedef enum logic [2:0] {s_idle, s_opcode, s_op_hi, s_op_lo, s_hold} state_e;

   state_e            state_q;
   logic [addr_w-1:0] pc_q;        // halfword address of the current instruction
   logic [addr_w-1:0] redir_pc_q;
   logic              redir_pend_q;
   logic              run_q;
   logic [15:0]       opcode_q;
   logic [31:0]       operand_q;
   logic              in_access;
   logic              redirect;
   logic [addr_w-1:0] redirect_pc;
   logic [addr_w-1:0] flush_hw;
   logic [addr_w-1:0] pc_step;

   assign in_access   = (state_q == s_opcode) || (state_q == s_op_hi) ||
                        (state_q == s_op_lo);
   assign flush_hw    = flush_pc_i[addr_w:1];
   // A flush during an access takes effect once that access is acked
   assign redirect    = flush_i || redir_pend_q;
   assign redirect_pc = flush_i ? flush_hw : redir_pc_q;
   assign pc_step     = is_long_form(opcode_q) ? addr_w'(3) : addr_w'(1);

   always_comb
   begin
      wb_req_o     = '0;
      wb_req_o.cyc = in_access;
      wb_req_o.stb = in_access;
      case (state_q)
         s_op_hi: wb_req_o.adr = pc_q + addr_w'(1);
         s_op_lo: wb_req_o.adr = pc_q + addr_w'(2);
         default: wb_req_o.adr = pc_q;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         state_q      <= s_idle;
         pc_q         <= '0;
         redir_pend_q <= 1'b0;
         run_q        <= 1'b0;
      end
      else
      begin
         run_q <= run_i;
         case (state_q)
            s_idle:
               if (run_i && !run_q)
               begin
                  pc_q    <= '0;
                  state_q <= s_opcode;
               end
            s_hold:
               if (flush_i)
               begin
                  pc_q    <= flush_hw;
                  state_q <= run_i ? s_opcode : s_idle;
               end
               else if (!stall_i)
               begin
                  pc_q    <= pc_q + pc_step;
                  state_q <= run_i ? s_opcode : s_idle;
               end
            default:
            begin
               if (flush_i)
               begin
                  redir_pend_q <= 1'b1;
                  redir_pc_q   <= flush_hw;
               end
               if (wb_rsp_i.ack)
               begin
                  redir_pend_q <= 1'b0;
                  if (!run_i)
                     state_q <= s_idle;
                  else if (redirect)
                  begin
                     pc_q    <= redirect_pc;
                     state_q <= s_opcode;
                  end
                  else if (state_q == s_opcode)
                  begin
                     opcode_q <= wb_rsp_i.dat;
                     state_q  <= is_long_form(wb_rsp_i.dat) ? s_op_hi : s_hold;
                  end
                  else if (state_q == s_op_hi)
                  begin
                     operand_q[31:16] <= wb_rsp_i.dat;
                     state_q          <= s_op_lo;
                  end
                  else
                  begin
                     operand_q[15:0] <= wb_rsp_i.dat;
                     state_q         <= s_hold;
                  end
               end
            end
         endcase
      end
   end

   assign fetch_o = '{valid:   (state_q == s_hold),
                      opcode:  opcode_q,
                      operand: operand_q,
                      pc:      {{(31 - addr_w){1'b0}}, pc_q, 1'b0}};

   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_req_o.stb |-> wb_req_o.cyc);

   // Request held until the slave answers, also across flush and run changes
   a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      wb_req_o.stb && !wb_rsp_i.ack |=> wb_req_o.stb && $stable(wb_req_o.adr));

endmodule

`default_nettype wire

/* src/cpu_decode.sv */
//------------------------------
// Decode stage. Turns one fetched instruction into a dec_t one cycle
// after it is accepted. stall_i holds the output, flush_i replaces
// it with a bubble. A nop opcode also leaves a bubble.
//------------------------------
`default_nettype none

module cpu_decode (
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire                    stall_i,
   input  wire                    flush_i,
   input  wire cpu_pkg::fetch_t   fetch_i,
   output cpu_pkg::dec_t          dec_o
);
   import cpu_pkg::*;

   pcb_t       rom_pcb;
   dec_t       dec_d;
   logic [7:0] hi;
   logic       form1;

   assign hi    = fetch_i.opcode[15:8];
   assign form1 = !hi[7];

   control_rom u_rom (
      .opcode_i (hi),
      .pcb_o    (rom_pcb)
   );

   always_comb
   begin
      dec_d          = '0;
      dec_d.op       = op_bad;
      dec_d.ri_a     = form1 ? fetch_i.opcode[7:4] : fetch_i.opcode[11:8];
      dec_d.ri_b     = fetch_i.opcode[3:0];
      dec_d.reg0_idx = dec_d.ri_a;
      dec_d.reg1_idx = dec_d.ri_b;
      dec_d.pcrel    = fetch_i.opcode[9:0];
      dec_d.pc       = fetch_i.pc;
      if (form1)
      begin
         dec_d.pcb = rom_pcb;
         // Defined form-1 bytes map straight onto op_e
         if ((hi <= 8'h0e) || ((hi >= 8'h19) && (hi <= 8'h39)))
            dec_d.op = op_e'(hi[5:0]);
         if (is_long_form(fetch_i.opcode))
            dec_d.operand = fetch_i.operand;
      end
      else if (!hi[6])
      begin
         case (hi[5:4])
            2'b00:   dec_d.op = op_inc;
            2'b01:   dec_d.op = op_dec;
            2'b10:   dec_d.op = op_gsr;
            default: dec_d.op = op_ssr;
         endcase
         if (!hi[5])
         begin
            dec_d.pcb     = pcb_reg_imm;
            dec_d.operand = {28'd0, fetch_i.opcode[3:0]};
         end
      end
      else
      begin
         // Form 3 conditional branches
         case (hi[5:2])
            4'd0:    dec_d.op = op_beq;
            4'd1:    dec_d.op = op_bne;
            4'd2:    dec_d.op = op_blt;
            4'd3:    dec_d.op = op_bgt;
            4'd4:    dec_d.op = op_bltu;
            4'd5:    dec_d.op = op_bgtu;
            4'd6:    dec_d.op = op_bge;
            4'd7:    dec_d.op = op_ble;
            4'd8:    dec_d.op = op_bgeu;
            4'd9:    dec_d.op = op_bleu;
            default: dec_d.op = op_bad;
         endcase
      end
      dec_d.valid = fetch_i.valid && (dec_d.op != op_nop);
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i || flush_i)
      begin
         dec_o.valid <= 1'b0;
         dec_o.op    <= op_nop;
      end
      else if (!stall_i)
      begin
         if (dec_d.valid)
            dec_o <= dec_d;
         else
         begin
            dec_o.valid <= 1'b0;
            dec_o.op    <= op_nop;
         end
      end
   end

   a_no_valid_nop: assert property (@(posedge clk_i) disable iff (rst_i)
      dec_o.valid |-> dec_o.op != op_nop);

endmodule

`default_nettype wire

/* src/wb_arbiter.sv */
//------------------------------
// Two-master Wishbone classic arbiter. m0 is the host and wins a tie.
// A grant is taken only on an idle bus and lasts until its master
// drops cyc.
//------------------------------
`default_nettype none

module wb_arbiter (
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire cpu_pkg::wb_req_t  m0_req_i,
   output cpu_pkg::wb_rsp_t       m0_rsp_o,
   input  wire cpu_pkg::wb_req_t  m1_req_i,
   output cpu_pkg::wb_rsp_t       m1_rsp_o,
   output cpu_pkg::wb_req_t       s_req_o,
   input  wire cpu_pkg::wb_rsp_t  s_rsp_i
);
   import cpu_pkg::*;

   typedef enum logic [1:0] {own_none, own_host, own_fetch} owner_e;

   owner_e owner_q;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         owner_q <= own_none;
      else
         case (owner_q)
            own_none:
               if (m0_req_i.cyc)
                  owner_q <= own_host;
               else if (m1_req_i.cyc)
                  owner_q <= own_fetch;
            own_host:
               if (!m0_req_i.cyc)
                  owner_q <= own_none;
            default:
               if (!m1_req_i.cyc)
                  owner_q <= own_none;
         endcase
   end

   always_comb
   begin
      s_req_o  = '0;
      m0_rsp_o = '0;
      m1_rsp_o = '0;
      case (owner_q)
         own_host:
         begin
            s_req_o  = m0_req_i;
            m0_rsp_o = s_rsp_i;
         end
         own_fetch:
         begin
            s_req_o  = m1_req_i;
            m1_rsp_o = s_rsp_i;
         end
         default: s_req_o = '0;
      endcase
   end

   // The slave answers a cycle late, so the grant must already have been held
   a_ack_host: assert property (@(posedge clk_i) disable iff (rst_i)
      m0_rsp_o.ack |-> $past(owner_q == own_host));
   a_ack_fetch: assert property (@(posedge clk_i) disable iff (rst_i)
      m1_rsp_o.ack |-> $past(owner_q == own_fetch));

endmodule

`default_nettype wire

/* src/inst_memory.sv */
//------------------------------
// Instruction RAM of 16-bit halfwords on a Wishbone classic slave.
// Ack comes one cycle after stb and drops for a cycle between
// accesses, so each access is acked once.
//------------------------------
`default_nettype none

module inst_memory (
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire cpu_pkg::wb_req_t  wb_req_i,
   output cpu_pkg::wb_rsp_t       wb_rsp_o
);
   import cpu_pkg::*;

   logic [15:0] mem [mem_depth];
   logic [15:0] rd_q;
   logic        ack_q;
   logic        access;

   assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         ack_q <= 1'b0;
      else
         ack_q <= access;
   end

   always_ff @(posedge clk_i)
   begin
      if (access)
      begin
         if (wb_req_i.we)
            mem[wb_req_i.adr] <= wb_req_i.dat;
         rd_q <= mem[wb_req_i.adr];
      end
   end

   assign wb_rsp_o = '{ack: ack_q, dat: rd_q};

endmodule

`default_nettype wire

/* src/cpu_frontend.sv */
//------------------------------
// Front-end top level. Fetch and the host port share the instruction
// RAM through the arbiter; decoded instructions leave on dec_o.
// Hold run_i low while the host loads a program.
//------------------------------
`default_nettype none

module cpu_frontend (
   input  wire                    clk_i,
   input  wire                    rst_i,
   input  wire                    run_i,
   input  wire                    stall_i,
   input  wire                    flush_i,
   input  wire [31:0]             flush_pc_i,
   input  wire cpu_pkg::wb_req_t  host_req_i,
   output cpu_pkg::wb_rsp_t       host_rsp_o,
   output cpu_pkg::dec_t          dec_o
);
   import cpu_pkg::*;

   wb_req_t fetch_req;
   wb_rsp_t fetch_rsp;
   wb_req_t mem_req;
   wb_rsp_t mem_rsp;
   fetch_t  fetch_inst;

   fetch_unit u_fetch (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .run_i      (run_i),
      .stall_i    (stall_i),
      .flush_i    (flush_i),
      .flush_pc_i (flush_pc_i),
      .wb_req_o   (fetch_req),
      .wb_rsp_i   (fetch_rsp),
      .fetch_o    (fetch_inst)
   );

   cpu_decode u_decode (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .stall_i (stall_i),
      .flush_i (flush_i),
      .fetch_i (fetch_inst),
      .dec_o   (dec_o)
   );

   // Host on m0 so a program load is never starved by fetch
   wb_arbiter u_arb (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .m0_req_i (host_req_i),
      .m0_rsp_o (host_rsp_o),
      .m1_req_i (fetch_req),
      .m1_rsp_o (fetch_rsp),
      .s_req_o  (mem_req),
      .s_rsp_i  (mem_rsp)
   );

   inst_memory u_mem (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .wb_req_i (mem_req),
      .wb_rsp_o (mem_rsp)
   );

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
//------------------------------
// Clock and reset for the testbench. Period of 100 time units,
// reset held high for the first 8 rising edges.
//------------------------------
`default_nettype none

module clock_gen (
   output logic clk_o,
   output logic rst_o
);

   initial
   begin
      clk_o = 1'b0;
      forever #50 clk_o = ~clk_o;
   end

   initial
   begin
      rst_o = 1'b1;
      repeat (8) @(posedge clk_o);
      #10 rst_o = 1'b0;
   end

endmodule

`default_nettype wire

/* dv/tb_cpu_frontend.sv */
//------------------------------
// Testbench for the instruction front end. Loads a random program
// through the host port, reads it back, then runs fetch and decode
// under random stall, flush and host traffic. A reference decoder
// predicts every valid decoded instruction.
//------------------------------
`default_nettype none

module tb_cpu_frontend;
   import cpu_pkg::*;

   localparam int n_inst     = 200;
   localparam int max_flush  = 3;
   localparam int flush_back = 30;

   logic        clk_i;
   logic        rst_i;
   logic        run_i;
   logic        stall_i;
   logic        flush_i;
   logic [31:0] flush_pc_i;
   wb_req_t     host_req;
   wb_rsp_t     host_rsp;
   dec_t        dec_o;

   // Program image and the instruction list the model walks
   logic [15:0] image [0:1023];
   logic [15:0] inst_opc [0:n_inst-1];
   logic [31:0] inst_imm [0:n_inst-1];
   int          inst_hw [0:n_inst-1];
   int          n_hw;

   logic [31:0] rng_main;
   logic [31:0] rng_drv;
   int          model_idx;
   int          flush_idx;
   int          flushes;
   int          wd_cycles;
   logic        running;
   logic        done;
   logic        stall_prev;
   logic        flush_prev;
   dec_t        prev_dec;

   clock_gen u_clk (
      .clk_o (clk_i),
      .rst_o (rst_i)
   );

   cpu_frontend UUT (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .run_i      (run_i),
      .stall_i    (stall_i),
      .flush_i    (flush_i),
      .flush_pc_i (flush_pc_i),
      .host_req_i (host_req),
      .host_rsp_o (host_rsp),
      .dec_o      (dec_o)
   );

   function automatic logic [31:0] lcg_next(inout logic [31:0] state);
      state = state * 32'd1103515245 + 32'd12345;
      return state;
   endfunction

   // Opcodes that carry a 32-bit immediate
   function automatic logic has_imm(input logic [7:0] hi);
      return (hi == 8'h01) || (hi == 8'h08) || (hi == 8'h09) || (hi == 8'h1a);
   endfunction

   function automatic pcb_t ref_form1_pcb(input logic [7:0] hi);
      logic [pcb_w-1:0] bits;
      bits = '0;
      if (hi == 8'h01)
         bits = pcb_reg_imm;
      else if ((hi inside {8'h02, 8'h05, 8'h1b, 8'h20}) ||
               (hi inside {[8'h26:8'h2f]}) || (hi inside {[8'h31:8'h34]}))
         bits = pcb_alu;
      else if (hi == 8'h03)
         bits = pcb_jsra;
      else if (hi == 8'h04)
         bits = pcb_ret;
      else if (hi == 8'h06)
         bits = pcb_push;
      else if (hi == 8'h07)
         bits = pcb_pop;
      else if (hi == 8'h08)
         bits = pcb_lda;
      else if (hi == 8'h09)
         bits = pcb_sta;
      else if (hi inside {8'h0a, 8'h0c, 8'h1c, 8'h1d, 8'h21, 8'h22, 8'h36, 8'h38})
         bits = pcb_load;
      else if (hi inside {8'h0b, 8'h0d, 8'h1e, 8'h1f, 8'h23, 8'h24, 8'h37, 8'h39})
         bits = pcb_store;
      else if (hi == 8'h19)
         bits = pcb_call;
      else if (hi == 8'h1a)
         bits = pcb_jmpa;
      else if (hi inside {8'h25, 8'h30})
         bits = pcb_jump;
      return pcb_t'(bits);
   endfunction

   // Reference decode of one instruction at halfword address hw
   function automatic dec_t ref_decode(input logic [15:0] opc, input logic [31:0] imm,
                                       input int hw);
      dec_t       d;
      logic [7:0] hi;
      hi         = opc[15:8];
      d          = '0;
      d.valid    = 1'b1;
      d.ri_a     = hi[7] ? opc[11:8] : opc[7:4];
      d.ri_b     = opc[3:0];
      d.reg0_idx = d.ri_a;
      d.reg1_idx = d.ri_b;
      d.pcrel    = opc[9:0];
      d.pc       = 32'(hw * 2);
      if (!hi[7])
      begin
         // Form-1 operation codes equal their opcode byte
         if ((hi <= 8'h0e) || ((hi >= 8'h19) && (hi <= 8'h39)))
            d.op = op_e'(hi[5:0]);
         else
            d.op = op_bad;
         d.pcb = ref_form1_pcb(hi);
         if (has_imm(hi))
            d.operand = imm;
      end
      else if (!hi[6])
      begin
         case (hi[5:4])
            2'b00:   d.op = op_inc;
            2'b01:   d.op = op_dec;
            2'b10:   d.op = op_gsr;
            default: d.op = op_ssr;
         endcase
         if (!hi[5])
         begin
            d.pcb     = pcb_t'(6'b100010);
            d.operand = {28'd0, opc[3:0]};
         end
      end
      else
      begin
         case (hi[5:2])
            4'd0:    d.op = op_beq;
            4'd1:    d.op = op_bne;
            4'd2:    d.op = op_blt;
            4'd3:    d.op = op_bgt;
            4'd4:    d.op = op_bltu;
            4'd5:    d.op = op_bgtu;
            4'd6:    d.op = op_bge;
            4'd7:    d.op = op_ble;
            4'd8:    d.op = op_bgeu;
            4'd9:    d.op = op_bleu;
            default: d.op = op_bad;
         endcase
      end
      return d;
   endfunction

   task automatic stop_run(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_dec(input dec_t got, input dec_t exp);
      if (got !== exp)
         stop_run($sformatf("FAIL @%0t: decode at pc %h got %s %h, expected %s %h",
                            $time, exp.pc, got.op.name(), got, exp.op.name(), exp));
   endtask

   task automatic check_host_read(input logic [15:0] got, input logic [15:0] exp,
                                  input int adr);
      if (got !== exp)
         stop_run($sformatf("FAIL @%0t: host read at %h got %h, expected %h",
                            $time, adr, got, exp));
   endtask

   task automatic host_access(input logic we, input int adr, input logic [15:0] wdat,
                              output logic [15:0] rdat);
      int waited;
      @(posedge clk_i);
      #10;
      host_req.cyc = 1'b1;
      host_req.stb = 1'b1;
      host_req.we  = we;
      host_req.adr = addr_w'(adr);
      host_req.dat = wdat;
      waited = 0;
      do
      begin
         @(negedge clk_i);
         waited++;
         if (waited > 100)
            stop_run("Host access was never acknowledged");
      end
      while (!host_rsp.ack);
      rdat = host_rsp.dat;
      @(posedge clk_i);
      #10;
      host_req = '0;
   endtask

   task automatic make_program();
      logic [31:0] r1;
      logic [31:0] r2;
      logic [31:0] r3;
      logic [31:0] r4;
      logic [7:0]  hi;
      n_hw = 0;
      for (int i = 0; i < n_inst; i++)
      begin
         r1 = lcg_next(rng_main);
         r2 = lcg_next(rng_main);
         // Four classes in equal share: form 1, inc/dec, gsr/ssr, branch
         case (r1[31:30])
            2'd0:
               if (r1[29])
                  case (r1[28:27])
                     2'd0:    hi = 8'h01;
                     2'd1:    hi = 8'h08;
                     2'd2:    hi = 8'h09;
                     default: hi = 8'h1a;
                  endcase
               else
                  hi = {2'b00, r1[26:21]};
            2'd1:    hi = {3'b100, r1[25:21]};
            2'd2:    hi = {3'b101, r1[25:21]};
            default: hi = {2'b11, r1[26:21]};
         endcase
         r3            = lcg_next(rng_main);
         r4            = lcg_next(rng_main);
         inst_opc[i]   = {hi, r2[23:16]};
         inst_imm[i]   = {r3[31:16], r4[31:16]};
         inst_hw[i]    = n_hw;
         image[n_hw]   = inst_opc[i];
         n_hw++;
         if (has_imm(hi))
         begin
            image[n_hw]     = inst_imm[i][31:16];
            image[n_hw + 1] = inst_imm[i][15:0];
            n_hw += 2;
         end
      end
      // Trailing nops so fetch runs past the end quietly
      for (int i = 0; i < 4; i++)
      begin
         image[n_hw] = 16'h0000;
         n_hw++;
      end
   endtask

   // Reference stream check, sampled mid-cycle where outputs are stable.
   // Any opcode with high byte zero is a nop and never leaves decode valid
   always @(negedge clk_i)
   begin
      if (rst_i)
      begin
         stall_prev = 1'b0;
         flush_prev = 1'b0;
      end
      else
      begin
         if (running && !done)
         begin
            if (stall_prev && !flush_prev && (dec_o !== prev_dec))
               stop_run($sformatf("FAIL @%0t: decode output changed while stalled", $time));
            if (dec_o.valid && !stall_prev)
            begin
               while ((model_idx < n_inst) && (inst_opc[model_idx][15:8] == 8'h00))
                  model_idx++;
               if (model_idx >= n_inst)
                  stop_run("Decoded an instruction beyond the end of the program");
               check_dec(dec_o, ref_decode(inst_opc[model_idx], inst_imm[model_idx],
                                           inst_hw[model_idx]));
               model_idx++;
               while ((model_idx < n_inst) && (inst_opc[model_idx][15:8] == 8'h00))
                  model_idx++;
               if (model_idx >= n_inst)
                  done = 1'b1;
            end
            // Flush takes effect at the coming edge
            if (flush_i && !done)
               model_idx = flush_idx;
         end
         prev_dec   = dec_o;
         stall_prev = stall_i;
         flush_prev = flush_i;
      end
   end

   // Random stall stretches and a few flushes back to earlier instructions
   initial
   begin
      int          stall_left;
      logic [31:0] r;
      int          t;
      stall_left = 0;
      wait (running);
      while (!done)
      begin
         @(posedge clk_i);
         #10;
         flush_i = 1'b0;
         if (stall_left > 0)
         begin
            stall_i = 1'b1;
            stall_left--;
         end
         else
         begin
            stall_i = 1'b0;
            r = lcg_next(rng_drv);
            if (r[31:29] == 3'd0)
               stall_left = int'(r[27:25]) + 1;
         end
         if ((flushes < max_flush) && (model_idx >= 50 * (flushes + 1)) && !done)
         begin
            r = lcg_next(rng_drv);
            t = model_idx - 1 - int'(r[31:16] % flush_back);
            if (t < 0)
               t = 0;
            flush_idx  = t;
            flush_pc_i = 32'(inst_hw[t] * 2);
            flush_i    = 1'b1;
            flushes++;
         end
      end
      stall_i = 1'b0;
      flush_i = 1'b0;
   end

   initial
   begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge clk_i);
      stop_run("Watchdog timeout, the decoded stream did not reach the end of the program");
   end

   initial
   begin
      logic [15:0] rdat;
      logic [31:0] r;
      int          a;
      run_i      = 1'b0;
      stall_i    = 1'b0;
      flush_i    = 1'b0;
      flush_pc_i = '0;
      host_req   = '0;
      rng_main   = 32'd36;
      model_idx  = 0;
      flush_idx  = 0;
      flushes    = 0;
      wd_cycles  = 0;
      running    = 1'b0;
      done       = 1'b0;
      prev_dec   = '0;
      make_program();
      rng_drv    = lcg_next(rng_main);
      // Instruction budget covers replays after flushes, loading costs two passes
      wd_cycles  = (n_inst + max_flush * flush_back) * 20 + n_hw * 2 * 8 + 400;

      wait (!rst_i);
      @(negedge clk_i);
      if (dec_o.valid || (dec_o.op != op_nop))
         stop_run("Decode output is not an invalid nop after reset");

      for (int i = 0; i < n_hw; i++)
         host_access(1'b1, i, image[i], rdat);
      for (int i = 0; i < n_hw; i++)
      begin
         host_access(1'b0, i, 16'h0000, rdat);
         check_host_read(rdat, image[i], i);
      end

      @(posedge clk_i);
      #10;
      run_i   = 1'b1;
      running = 1'b1;

      // Host reads that compete with fetch for the bus
      for (int k = 0; (k < 6) && !done; k++)
      begin
         r = lcg_next(rng_main);
         repeat (20 + int'(r[31:26])) @(posedge clk_i);
         a = int'(r[23:8]) % n_hw;
         host_access(1'b0, a, 16'h0000, rdat);
         check_host_read(rdat, image[a], a);
      end

      wait (done);
      @(posedge clk_i);
      #10;
      run_i   = 1'b0;
      running = 1'b0;
      $display("Test completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* list.f */
src/cpu_pkg.sv
src/control_rom.sv
src/fetch_unit.sv
src/cpu_decode.sv
src/wb_arbiter.sv
src/inst_memory.sv
src/cpu_frontend.sv
dv/clock_gen.sv
dv/tb_cpu_frontend.sv

/* Makefile */
# Verilator build for the instruction front end testbench
TOP = tb_cpu_frontend

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		--Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
